// File: hw/mcu_pkg.sv
/*
 * mini MCU shared definitions
 * memory map, peripheral register offsets, bus widths and bus target encoding
 */
package mcu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [7:0]  gpio_ao_t;

  // byte offset inside the always-on peripheral window
  typedef logic [11:0] ao_offset_t;

  typedef enum logic [1:0] {
    TARGET_RAM,
    TARGET_AO,
    TARGET_NONE
  } bus_target_e;

  // memory banks
  localparam int unsigned NUM_BANKS  = 2;
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned WORD_IDX_W = $clog2(BANK_WORDS);
  localparam int unsigned BANK_IDX_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  localparam addr_t RAM_START = 32'h0000_0000;
  localparam addr_t RAM_SIZE  = NUM_BANKS * BANK_WORDS * 4;

  localparam addr_t AO_PERIPH_START = 32'h2000_0000;
  localparam addr_t AO_PERIPH_SIZE  = 32'h0000_1000;

  // always-on register map
  localparam ao_offset_t BOOT_STATUS_OFFSET       = 12'h000;
  localparam ao_offset_t EXIT_VALID_OFFSET        = 12'h004;
  localparam ao_offset_t EXIT_VALUE_OFFSET        = 12'h008;
  localparam ao_offset_t GPIO_OUT_OFFSET          = 12'h00C;
  localparam ao_offset_t GPIO_OE_OFFSET           = 12'h010;
  localparam ao_offset_t GPIO_IN_OFFSET           = 12'h014;
  localparam ao_offset_t FAST_INTR_ENABLE_OFFSET  = 12'h018;
  localparam ao_offset_t FAST_INTR_PENDING_OFFSET = 12'h01C;

endpackage

// File: hw/ram_bank.sv
/*
 * single RAM bank, word addressed
 * byte-enable writes and a registered read port
 */
module ram_bank #(
  parameter int unsigned WORDS = mcu_pkg::BANK_WORDS
) (
  input  logic                     clk_i,
  input  logic                     en_i,
  input  logic                     we_i,
  input  mcu_pkg::be_t             be_i,
  input  logic [$clog2(WORDS)-1:0] word_i,
  input  mcu_pkg::data_t           wdata_i,
  output mcu_pkg::data_t           rdata_o
);

  mcu_pkg::data_t mem [WORDS];
  mcu_pkg::data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < $bits(mcu_pkg::be_t); b++) begin
          if (be_i[b]) begin
            mem[word_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hw/memory_subsystem.sv
/*
 * memory subsystem
 * contiguous RAM banks, one bank enabled per access, registered read select
 */
module memory_subsystem (
  input  logic           clk_i,
  input  logic           ram_req_i,
  input  logic           we_i,
  input  mcu_pkg::be_t   be_i,
  input  mcu_pkg::addr_t addr_i,
  input  mcu_pkg::data_t wdata_i,
  output mcu_pkg::data_t rdata_o
);

  localparam int unsigned WordW = mcu_pkg::WORD_IDX_W;
  localparam int unsigned BankW = mcu_pkg::BANK_IDX_W;

  mcu_pkg::addr_t   ram_off;
  logic [WordW-1:0] word_idx;
  logic [BankW-1:0] bank_idx;
  logic [BankW-1:0] bank_q;
  mcu_pkg::data_t   bank_rdata [mcu_pkg::NUM_BANKS];

  // word address first, bank index right above it
  assign ram_off  = addr_i - mcu_pkg::RAM_START;
  assign word_idx = ram_off[2 +: WordW];
  assign bank_idx = ram_off[2 + WordW +: BankW];

  for (genvar i = 0; i < mcu_pkg::NUM_BANKS; i++) begin : gen_bank
    ram_bank #(
      .WORDS (mcu_pkg::BANK_WORDS)
    ) ram_bank_i (
      .clk_i,
      .en_i    (ram_req_i && (bank_idx == BankW'(i))),
      .we_i,
      .be_i,
      .word_i  (word_idx),
      .wdata_i,
      .rdata_o (bank_rdata[i])
    );
  end

  // remember which bank answers in the next cycle
  always_ff @(posedge clk_i) begin
    if (ram_req_i) begin
      bank_q <= bank_idx;
    end
  end

  assign rdata_o = bank_rdata[bank_q];

endmodule

// File: hw/gpio_ao.sv
/*
 * always-on GPIO
 * output and enable registers, two-flop input sync, rising edge pulses
 */
module gpio_ao (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              out_we_i,
  input  logic              oe_we_i,
  input  mcu_pkg::gpio_ao_t wdata_i,
  input  mcu_pkg::gpio_ao_t gpio_i,
  output mcu_pkg::gpio_ao_t gpio_o,
  output mcu_pkg::gpio_ao_t gpio_oe_o,
  output mcu_pkg::gpio_ao_t gpio_in_o,
  output mcu_pkg::gpio_ao_t rise_o
);

  mcu_pkg::gpio_ao_t out_q;
  mcu_pkg::gpio_ao_t oe_q;
  mcu_pkg::gpio_ao_t sync1_q;
  mcu_pkg::gpio_ao_t sync2_q;
  mcu_pkg::gpio_ao_t prev_q;
  mcu_pkg::gpio_ao_t rise_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      rise_q  <= '0;
    end else begin
      if (out_we_i) out_q <= wdata_i;
      if (oe_we_i)  oe_q  <= wdata_i;
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      // edge seen on the synchronized value only
      prev_q  <= sync2_q;
      rise_q  <= sync2_q & ~prev_q;
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign gpio_in_o = sync2_q;
  assign rise_o    = rise_q;

endmodule

// File: hw/fast_intr_ctrl.sv
/*
 * fast interrupt controller
 * latches GPIO edges as pending bits, masked by an enable register
 */
module fast_intr_ctrl (
  input  logic              clk_i,
  input  logic              reset_i,
  input  mcu_pkg::gpio_ao_t rise_i,
  input  logic              enable_we_i,
  input  logic              clear_we_i,
  input  mcu_pkg::gpio_ao_t wdata_i,
  output mcu_pkg::gpio_ao_t enable_o,
  output mcu_pkg::gpio_ao_t pending_o,
  output mcu_pkg::gpio_ao_t irq_o
);

  mcu_pkg::gpio_ao_t enable_q;
  mcu_pkg::gpio_ao_t pending_q;
  mcu_pkg::gpio_ao_t clear_mask;

  // write one to clear
  assign clear_mask = clear_we_i ? wdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q  <= '0;
      pending_q <= '0;
    end else begin
      if (enable_we_i) begin
        enable_q <= wdata_i;
      end
      // a new edge beats a clear in the same cycle
      pending_q <= (pending_q & ~clear_mask) | rise_i;
    end
  end

  assign enable_o  = enable_q;
  assign pending_o = pending_q;
  assign irq_o     = pending_q & enable_q;

endmodule

// File: hw/ao_peripheral_subsystem.sv
/*
 * always-on peripheral block
 * boot status, exit registers, GPIO and fast interrupt registers
 */
module ao_peripheral_subsystem (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              ao_req_i,
  input  logic              we_i,
  input  mcu_pkg::be_t      be_i,
  input  mcu_pkg::addr_t    addr_i,
  input  mcu_pkg::data_t    wdata_i,
  output mcu_pkg::data_t    rdata_o,
  input  logic              boot_select_i,
  input  logic              execute_from_flash_i,
  output logic              exit_valid_o,
  output mcu_pkg::data_t    exit_value_o,
  input  mcu_pkg::gpio_ao_t gpio_i,
  output mcu_pkg::gpio_ao_t gpio_o,
  output mcu_pkg::gpio_ao_t gpio_oe_o,
  output mcu_pkg::gpio_ao_t irq_fast_o
);

  mcu_pkg::addr_t     off_full;
  mcu_pkg::ao_offset_t offset;
  logic               wr;
  logic               wr_low;
  logic               exit_valid_q;
  mcu_pkg::data_t     exit_value_q;
  mcu_pkg::data_t     rdata_d;
  mcu_pkg::data_t     rdata_q;
  mcu_pkg::gpio_ao_t  gpio_in;
  mcu_pkg::gpio_ao_t  gpio_rise;
  mcu_pkg::gpio_ao_t  intr_enable;
  mcu_pkg::gpio_ao_t  intr_pending;

  assign off_full = addr_i - mcu_pkg::AO_PERIPH_START;
  assign offset   = off_full[$bits(mcu_pkg::ao_offset_t)-1:0];
  assign wr       = ao_req_i && we_i;
  // 8 bit registers live in byte lane 0
  assign wr_low   = wr && be_i[0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else begin
      if (wr_low && offset == mcu_pkg::EXIT_VALID_OFFSET) begin
        exit_valid_q <= wdata_i[0];
      end
      if (wr && offset == mcu_pkg::EXIT_VALUE_OFFSET) begin
        for (int b = 0; b < $bits(mcu_pkg::be_t); b++) begin
          if (be_i[b]) begin
            exit_value_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  gpio_ao gpio_ao_i (
    .clk_i,
    .reset_i,
    .out_we_i  (wr_low && offset == mcu_pkg::GPIO_OUT_OFFSET),
    .oe_we_i   (wr_low && offset == mcu_pkg::GPIO_OE_OFFSET),
    .wdata_i   (wdata_i[7:0]),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_in_o (gpio_in),
    .rise_o    (gpio_rise)
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .reset_i,
    .rise_i      (gpio_rise),
    .enable_we_i (wr_low && offset == mcu_pkg::FAST_INTR_ENABLE_OFFSET),
    .clear_we_i  (wr_low && offset == mcu_pkg::FAST_INTR_PENDING_OFFSET),
    .wdata_i     (wdata_i[7:0]),
    .enable_o    (intr_enable),
    .pending_o   (intr_pending),
    .irq_o       (irq_fast_o)
  );

  // read mux, unlisted offsets fall through to zero
  always_comb begin
    case (offset)
      mcu_pkg::BOOT_STATUS_OFFSET:       rdata_d = {30'b0, execute_from_flash_i, boot_select_i};
      mcu_pkg::EXIT_VALID_OFFSET:        rdata_d = {31'b0, exit_valid_q};
      mcu_pkg::EXIT_VALUE_OFFSET:        rdata_d = exit_value_q;
      mcu_pkg::GPIO_OUT_OFFSET:          rdata_d = {24'b0, gpio_o};
      mcu_pkg::GPIO_OE_OFFSET:           rdata_d = {24'b0, gpio_oe_o};
      mcu_pkg::GPIO_IN_OFFSET:           rdata_d = {24'b0, gpio_in};
      mcu_pkg::FAST_INTR_ENABLE_OFFSET:  rdata_d = {24'b0, intr_enable};
      mcu_pkg::FAST_INTR_PENDING_OFFSET: rdata_d = {24'b0, intr_pending};
      default:                           rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (ao_req_i) begin
      rdata_q <= we_i ? '0 : rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hw/system_bus.sv
/*
 * system bus
 * decodes the master address, grants at once and routes the read response
 */
module system_bus (
  input  logic           clk_i,
  input  logic           reset_i,

  input  logic           bus_req_i,
  input  logic           bus_we_i,
  input  mcu_pkg::be_t   bus_be_i,
  input  mcu_pkg::addr_t bus_addr_i,
  input  mcu_pkg::data_t bus_wdata_i,
  output logic           bus_gnt_o,
  output logic           bus_rvalid_o,
  output mcu_pkg::data_t bus_rdata_o,

  output logic           ram_req_o,
  output logic           ao_req_o,
  output logic           slv_we_o,
  output mcu_pkg::be_t   slv_be_o,
  output mcu_pkg::addr_t slv_addr_o,
  output mcu_pkg::data_t slv_wdata_o,
  input  mcu_pkg::data_t ram_rdata_i,
  input  mcu_pkg::data_t ao_rdata_i
);

  mcu_pkg::addr_t      ram_off;
  mcu_pkg::addr_t      ao_off;
  mcu_pkg::bus_target_e target_d;
  mcu_pkg::bus_target_e target_q;
  logic                rvalid_q;
  logic                we_q;

  // region decode, offsets wrap below the base so one compare suffices
  assign ram_off = bus_addr_i - mcu_pkg::RAM_START;
  assign ao_off  = bus_addr_i - mcu_pkg::AO_PERIPH_START;

  always_comb begin
    if (ram_off < mcu_pkg::RAM_SIZE) begin
      target_d = mcu_pkg::TARGET_RAM;
    end else if (ao_off < mcu_pkg::AO_PERIPH_SIZE) begin
      target_d = mcu_pkg::TARGET_AO;
    end else begin
      target_d = mcu_pkg::TARGET_NONE;
    end
  end

  // no target ever stalls
  assign bus_gnt_o = bus_req_i;

  assign ram_req_o   = bus_req_i && (target_d == mcu_pkg::TARGET_RAM);
  assign ao_req_o    = bus_req_i && (target_d == mcu_pkg::TARGET_AO);
  assign slv_we_o    = bus_we_i;
  assign slv_be_o    = bus_be_i;
  assign slv_addr_o  = bus_addr_i;
  assign slv_wdata_o = bus_wdata_i;

  // response phase tracking, one cycle behind the grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      we_q     <= 1'b0;
      target_q <= mcu_pkg::TARGET_NONE;
    end else begin
      rvalid_q <= bus_req_i;
      we_q     <= bus_we_i;
      target_q <= bus_req_i ? target_d : mcu_pkg::TARGET_NONE;
    end
  end

  assign bus_rvalid_o = rvalid_q;

  always_comb begin
    bus_rdata_o = '0;
    if (!we_q) begin
      case (target_q)
        mcu_pkg::TARGET_RAM: bus_rdata_o = ram_rdata_i;
        mcu_pkg::TARGET_AO:  bus_rdata_o = ao_rdata_i;
        default:             bus_rdata_o = '0;
      endcase
    end
  end

endmodule

// File: hw/mini_mcu.sv
/*
 * mini MCU top level
 * external bus master port, banked RAM and always-on peripherals
 */
module mini_mcu (
  input  logic             clk_i,
  input  logic             reset_i,

  input  logic             bus_req_i,
  input  logic             bus_we_i,
  input  mcu_pkg::be_t     bus_be_i,
  input  mcu_pkg::addr_t   bus_addr_i,
  input  mcu_pkg::data_t   bus_wdata_i,
  output logic             bus_gnt_o,
  output logic             bus_rvalid_o,
  output mcu_pkg::data_t   bus_rdata_o,

  input  logic             boot_select_i,
  input  logic             execute_from_flash_i,
  output logic             exit_valid_o,
  output mcu_pkg::data_t   exit_value_o,

  input  mcu_pkg::gpio_ao_t gpio_i,
  output mcu_pkg::gpio_ao_t gpio_o,
  output mcu_pkg::gpio_ao_t gpio_oe_o,
  output mcu_pkg::gpio_ao_t irq_fast_o
);

  // shared request fields towards both targets
  logic           ram_req;
  logic           ao_req;
  logic           slv_we;
  mcu_pkg::be_t   slv_be;
  mcu_pkg::addr_t slv_addr;
  mcu_pkg::data_t slv_wdata;
  mcu_pkg::data_t ram_rdata;
  mcu_pkg::data_t ao_rdata;

  system_bus system_bus_i (
    .clk_i,
    .reset_i,
    .bus_req_i,
    .bus_we_i,
    .bus_be_i,
    .bus_addr_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .ram_req_o   (ram_req),
    .ao_req_o    (ao_req),
    .slv_we_o    (slv_we),
    .slv_be_o    (slv_be),
    .slv_addr_o  (slv_addr),
    .slv_wdata_o (slv_wdata),
    .ram_rdata_i (ram_rdata),
    .ao_rdata_i  (ao_rdata)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .ram_req_i (ram_req),
    .we_i      (slv_we),
    .be_i      (slv_be),
    .addr_i    (slv_addr),
    .wdata_i   (slv_wdata),
    .rdata_o   (ram_rdata)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .reset_i,
    .ao_req_i  (ao_req),
    .we_i      (slv_we),
    .be_i      (slv_be),
    .addr_i    (slv_addr),
    .wdata_i   (slv_wdata),
    .rdata_o   (ao_rdata),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o,
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_fast_o
  );

endmodule

// File: bench/tb_ref.svh
/*
 * testbench reference model
 * LCG stimulus, RAM and register models, bus master tasks
 */
`ifndef TB_REF_SVH
`define TB_REF_SVH

  mcu_pkg::data_t    lcg_state = 32'd6;
  mcu_pkg::data_t    ram_model [mcu_pkg::NUM_BANKS * mcu_pkg::BANK_WORDS];
  mcu_pkg::data_t    exp_q [$];
  logic              ref_exit_valid;
  mcu_pkg::data_t    ref_exit_value;
  mcu_pkg::gpio_ao_t ref_gpio_out;
  mcu_pkg::gpio_ao_t ref_gpio_oe;
  mcu_pkg::gpio_ao_t ref_enable;
  mcu_pkg::gpio_ao_t ref_pending;
  mcu_pkg::gpio_ao_t ref_pins;

  function automatic mcu_pkg::data_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic bit in_ram(input mcu_pkg::addr_t addr);
    return (addr - mcu_pkg::RAM_START) < mcu_pkg::NUM_BANKS * mcu_pkg::BANK_WORDS * 4;
  endfunction

  function automatic bit in_ao(input mcu_pkg::addr_t addr);
    return (addr - mcu_pkg::AO_PERIPH_START) < mcu_pkg::AO_PERIPH_SIZE;
  endfunction

  // pad model, driven pins loop back and the others follow the outside world
  function automatic mcu_pkg::gpio_ao_t pad_value(input mcu_pkg::gpio_ao_t ext);
    return (ref_gpio_out & ref_gpio_oe) | (ext & ~ref_gpio_oe);
  endfunction

  function automatic mcu_pkg::data_t ao_model(input mcu_pkg::addr_t addr);
    mcu_pkg::addr_t off;
    off = addr - mcu_pkg::AO_PERIPH_START;
    case (off[11:0])
      mcu_pkg::BOOT_STATUS_OFFSET:       return {30'b0, execute_from_flash_i, boot_select_i};
      mcu_pkg::EXIT_VALID_OFFSET:        return {31'b0, ref_exit_valid};
      mcu_pkg::EXIT_VALUE_OFFSET:        return ref_exit_value;
      mcu_pkg::GPIO_OUT_OFFSET:          return {24'b0, ref_gpio_out};
      mcu_pkg::GPIO_OE_OFFSET:           return {24'b0, ref_gpio_oe};
      mcu_pkg::GPIO_IN_OFFSET:           return {24'b0, ref_pins};
      mcu_pkg::FAST_INTR_ENABLE_OFFSET:  return {24'b0, ref_enable};
      mcu_pkg::FAST_INTR_PENDING_OFFSET: return {24'b0, ref_pending};
      default:                           return '0;
    endcase
  endfunction

  function automatic mcu_pkg::data_t expected_read(input mcu_pkg::addr_t addr);
    if (in_ram(addr)) begin
      return ram_model[(addr - mcu_pkg::RAM_START) >> 2];
    end else if (in_ao(addr)) begin
      return ao_model(addr);
    end
    return '0;
  endfunction

  function automatic void apply_write(input mcu_pkg::be_t be, input mcu_pkg::addr_t addr,
                                      input mcu_pkg::data_t wdata);
    mcu_pkg::addr_t off;
    mcu_pkg::data_t word;
    int unsigned    idx;
    off = addr - mcu_pkg::AO_PERIPH_START;
    if (in_ram(addr)) begin
      idx  = (addr - mcu_pkg::RAM_START) >> 2;
      word = ram_model[idx];
      for (int b = 0; b < 4; b++) begin
        if (be[b]) word[8*b +: 8] = wdata[8*b +: 8];
      end
      ram_model[idx] = word;
    end else if (in_ao(addr) && off[11:0] == mcu_pkg::EXIT_VALUE_OFFSET) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) ref_exit_value[8*b +: 8] = wdata[8*b +: 8];
      end
    end else if (in_ao(addr) && be[0]) begin
      case (off[11:0])
        mcu_pkg::EXIT_VALID_OFFSET:        ref_exit_valid = wdata[0];
        mcu_pkg::GPIO_OUT_OFFSET:          ref_gpio_out = wdata[7:0];
        mcu_pkg::GPIO_OE_OFFSET:           ref_gpio_oe = wdata[7:0];
        mcu_pkg::FAST_INTR_ENABLE_OFFSET:  ref_enable = wdata[7:0];
        mcu_pkg::FAST_INTR_PENDING_OFFSET: ref_pending = ref_pending & ~wdata[7:0];
        default: ;
      endcase
    end
  endfunction

  // request stays up afterwards, so consecutive calls run back to back
  task automatic bus_access(input logic we, input mcu_pkg::be_t be,
                            input mcu_pkg::addr_t addr, input mcu_pkg::data_t wdata);
    int waited;
    @(negedge clk_i);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_be_i    = be;
    bus_addr_i  = addr;
    bus_wdata_i = wdata;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!bus_gnt_o && waited < 8);
    if (!bus_gnt_o) abort_timeout("bus_gnt_o");
    grants++;
    exp_q.push_back(we ? '0 : expected_read(addr));
    if (we) apply_write(be, addr, wdata);
  endtask

  task automatic bus_idle();
    @(negedge clk_i);
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
  endtask

  // edges are latched as pending whatever the enable says
  task automatic drive_pins(input mcu_pkg::gpio_ao_t pins);
    @(negedge clk_i);
    gpio_i      = pins;
    ref_pending = ref_pending | (pins & ~ref_pins);
    ref_pins    = pins;
  endtask

  // two sync flops, edge pulse, pending flop
  task automatic settle();
    repeat (4) @(negedge clk_i);
  endtask

`endif

// File: bench/tb_mini_mcu.sv
/*
 * testbench for the mini MCU
 * plays the bus master and checks every response against a reference model
 */
module tb_mini_mcu;
  timeunit 1ns;
  timeprecision 100ps;

  logic              clk_i;
  logic              reset_i;
  logic              bus_req_i;
  logic              bus_we_i;
  mcu_pkg::be_t      bus_be_i;
  mcu_pkg::addr_t    bus_addr_i;
  mcu_pkg::data_t    bus_wdata_i;
  logic              bus_gnt_o;
  logic              bus_rvalid_o;
  mcu_pkg::data_t    bus_rdata_o;
  logic              boot_select_i;
  logic              execute_from_flash_i;
  logic              exit_valid_o;
  mcu_pkg::data_t    exit_value_o;
  mcu_pkg::gpio_ao_t gpio_i;
  mcu_pkg::gpio_ao_t gpio_o;
  mcu_pkg::gpio_ao_t gpio_oe_o;
  mcu_pkg::gpio_ao_t irq_fast_o;

  int checks;
  int errors;
  int grants;
  int responses;
  bit mon_enable;

  `include "tb_ref.svh"

  localparam mcu_pkg::addr_t AO = mcu_pkg::AO_PERIPH_START;

  mini_mcu i_dut (
    .clk_i,
    .reset_i,
    .bus_req_i,
    .bus_we_i,
    .bus_be_i,
    .bus_addr_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o,
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_fast_o
  );

  always #20 clk_i = ~clk_i;

  task automatic check_value(input string name, input mcu_pkg::data_t exp,
                             input mcu_pkg::data_t act);
    checks++;
    assert (act === exp) else begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%-10s finished with %0d errors", name, errors - err_before);
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 10) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) abort_timeout("outstanding bus responses");
  endtask

  task automatic wait_irq(input mcu_pkg::gpio_ao_t mask);
    int waited;
    waited = 0;
    while ((irq_fast_o & mask) != mask && waited < 20) begin
      @(negedge clk_i);
      waited++;
    end
    if ((irq_fast_o & mask) != mask) abort_timeout("irq_fast_o");
  endtask

  // every grant owes exactly one response on the following cycle
  always @(negedge clk_i) begin
    if (mon_enable) begin
      checks++;
      if (exp_q.size() > 0) begin
        assert (bus_rvalid_o === 1'b1) else begin
          $display("at %0t bus_rvalid_o did not follow the grant by one cycle", $time);
          errors++;
        end
        if (bus_rvalid_o === 1'b1) responses++;
        check_value("bus_rdata_o", exp_q.pop_front(), bus_rdata_o);
      end else begin
        assert (bus_rvalid_o === 1'b0) else begin
          $display("at %0t bus_rvalid_o is high with no access granted", $time);
          errors++;
        end
      end
    end
  end

  // no stalls, a request is granted in its own cycle and only then
  always @(posedge clk_i) begin
    if (mon_enable) begin
      checks++;
      assert (bus_gnt_o === bus_req_i) else begin
        $display("FAIL %0t bus_gnt_o expected %b actual %b", $time, bus_req_i, bus_gnt_o);
        errors++;
      end
    end
  end

  initial begin
    mcu_pkg::addr_t    addrs [16];
    mcu_pkg::data_t    v;
    mcu_pkg::gpio_ao_t out8;
    int                err0;

    clk_i = 1'b0;
    reset_i = 1'b1;
    bus_req_i = 1'b0;
    bus_we_i = 1'b0;
    bus_be_i = '0;
    bus_addr_i = '0;
    bus_wdata_i = '0;
    boot_select_i = 1'b0;
    execute_from_flash_i = 1'b0;
    gpio_i = '0;
    ref_exit_valid = 1'b0;
    ref_exit_value = '0;
    ref_gpio_out = '0;
    ref_gpio_oe = '0;
    ref_enable = '0;
    ref_pending = '0;
    ref_pins = '0;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
    mon_enable = 1'b1;

    err0 = errors;
    check_value("bus_rvalid_o", '0, bus_rvalid_o);
    check_value("exit_valid_o", '0, exit_valid_o);
    check_value("exit_value_o", '0, exit_value_o);
    check_value("gpio_o", '0, gpio_o);
    check_value("gpio_oe_o", '0, gpio_oe_o);
    check_value("irq_fast_o", '0, irq_fast_o);
    report_test("reset", err0);

    // full words first, then a partial write on top, alternating banks
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = ((i % 2) * mcu_pkg::BANK_WORDS + next_rand() % mcu_pkg::BANK_WORDS) * 4;
      bus_access(1'b1, 4'hF, addrs[i], next_rand());
      bus_access(1'b1, mcu_pkg::be_t'(next_rand()), addrs[i], next_rand());
    end
    for (int i = 0; i < 16; i++) bus_access(1'b0, 4'hF, addrs[i], '0);
    bus_idle();
    drain_responses();
    report_test("ram", err0);

    // 0x800 is just past the RAM and aliases word 0 if decoding is wrong
    err0 = errors;
    bus_access(1'b1, 4'hF, 32'h0000_0000, 32'h1234_5678);
    bus_access(1'b1, 4'hF, 32'h0000_0800, 32'hDEAD_BEEF);
    bus_access(1'b1, 4'hF, 32'h1000_0000, 32'hDEAD_BEEF);
    bus_access(1'b1, 4'hF, AO + 32'h20, 32'hFFFF_FFFF);
    bus_access(1'b0, 4'hF, 32'h0000_0000, '0);
    bus_access(1'b0, 4'hF, 32'h0000_0800, '0);
    bus_access(1'b0, 4'hF, 32'h1000_0000, '0);
    bus_access(1'b0, 4'hF, 32'h2000_1000, '0);
    bus_access(1'b0, 4'hF, 32'hFFFF_FFFC, '0);
    bus_access(1'b0, 4'hF, AO + 32'h20, '0);
    bus_access(1'b0, 4'hF, AO + 32'hFFC, '0);
    bus_idle();
    drain_responses();
    report_test("unmapped", err0);

    err0 = errors;
    for (int k = 0; k < 4; k++) begin
      bus_idle();
      boot_select_i = k[0];
      execute_from_flash_i = k[1];
      bus_access(1'b0, 4'hF, AO + mcu_pkg::BOOT_STATUS_OFFSET, '0);
    end
    bus_idle();
    drain_responses();
    report_test("boot", err0);

    err0 = errors;
    v = next_rand();
    bus_access(1'b1, 4'hF, AO + mcu_pkg::EXIT_VALUE_OFFSET, v);
    bus_access(1'b1, 4'hF, AO + mcu_pkg::EXIT_VALID_OFFSET, 32'h1);
    bus_idle();
    check_value("exit_value_o", v, exit_value_o);
    check_value("exit_valid_o", 32'h1, exit_valid_o);
    bus_access(1'b0, 4'hF, AO + mcu_pkg::EXIT_VALUE_OFFSET, '0);
    bus_access(1'b0, 4'hF, AO + mcu_pkg::EXIT_VALID_OFFSET, '0);
    bus_idle();
    drain_responses();
    report_test("exit", err0);

    err0 = errors;
    out8 = mcu_pkg::gpio_ao_t'(next_rand());
    bus_access(1'b1, 4'hF, AO + mcu_pkg::GPIO_OUT_OFFSET, out8);
    out8 = mcu_pkg::gpio_ao_t'(next_rand());
    bus_access(1'b1, 4'hF, AO + mcu_pkg::GPIO_OE_OFFSET, out8);
    bus_idle();
    check_value("gpio_o", ref_gpio_out, gpio_o);
    check_value("gpio_oe_o", ref_gpio_oe, gpio_oe_o);
    drive_pins(pad_value(8'h5A));
    settle();
    bus_access(1'b0, 4'hF, AO + mcu_pkg::GPIO_IN_OFFSET, '0);
    bus_access(1'b0, 4'hF, AO + mcu_pkg::GPIO_OUT_OFFSET, '0);
    bus_access(1'b0, 4'hF, AO + mcu_pkg::GPIO_OE_OFFSET, '0);
    bus_idle();
    drain_responses();
    report_test("gpio", err0);

    // pin 2 enabled, pin 5 left masked
    err0 = errors;
    bus_access(1'b1, 4'hF, AO + mcu_pkg::FAST_INTR_PENDING_OFFSET, 32'hFF);
    bus_access(1'b1, 4'hF, AO + mcu_pkg::GPIO_OE_OFFSET, 32'h0);
    bus_access(1'b1, 4'hF, AO + mcu_pkg::FAST_INTR_ENABLE_OFFSET, 32'h04);
    bus_idle();
    drive_pins(8'h00);
    settle();
    drive_pins(8'h04);
    wait_irq(8'h04);
    check_value("irq_fast_o", ref_pending & ref_enable, irq_fast_o);
    drive_pins(8'h24);
    settle();
    check_value("irq_fast_o", ref_pending & ref_enable, irq_fast_o);
    bus_access(1'b0, 4'hF, AO + mcu_pkg::FAST_INTR_PENDING_OFFSET, '0);
    bus_access(1'b1, 4'hF, AO + mcu_pkg::FAST_INTR_PENDING_OFFSET, 32'h04);
    bus_idle();
    check_value("irq_fast_o", ref_pending & ref_enable, irq_fast_o);
    bus_access(1'b0, 4'hF, AO + mcu_pkg::FAST_INTR_PENDING_OFFSET, '0);
    bus_idle();
    drain_responses();
    report_test("interrupt", err0);

    // mixed targets with no idle cycle in between
    err0 = errors;
    bus_access(1'b1, 4'hF, addrs[0], next_rand());
    bus_access(1'b0, 4'hF, addrs[0], '0);
    bus_access(1'b0, 4'hF, AO + mcu_pkg::BOOT_STATUS_OFFSET, '0);
    bus_access(1'b1, 4'h3, addrs[1], next_rand());
    bus_access(1'b0, 4'hF, addrs[1], '0);
    bus_access(1'b0, 4'hF, AO + mcu_pkg::EXIT_VALUE_OFFSET, '0);
    bus_access(1'b0, 4'hF, 32'h4000_0000, '0);
    bus_access(1'b0, 4'hF, addrs[0], '0);
    bus_idle();
    drain_responses();
    check_value("responses", grants, responses);
    report_test("pipeline", err0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+bench
hw/mcu_pkg.sv
hw/ram_bank.sv
hw/memory_subsystem.sv
hw/gpio_ao.sv
hw/fast_intr_ctrl.sv
hw/ao_peripheral_subsystem.sv
hw/system_bus.sv
hw/mini_mcu.sv
bench/tb_mini_mcu.sv

// File: Bender.yml
package:
  name: mini_mcu

sources:
  - files:
      - hw/mcu_pkg.sv
      - hw/ram_bank.sv
      - hw/memory_subsystem.sv
      - hw/gpio_ao.sv
      - hw/fast_intr_ctrl.sv
      - hw/ao_peripheral_subsystem.sv
      - hw/system_bus.sv
      - hw/mini_mcu.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_mini_mcu.sv
